/* nn_layer_core.f */
src/nn_layer_pkg.sv
src/nn_bus_pkg.sv
src/weight_loader.sv
src/neuron.sv
src/output_serializer.sv
src/nn_layer_core.sv
verification/weight_ram_model.sv
verification/nn_layer_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the nn_layer_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=nn_layer_core_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -f nn_layer_core.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** PASSED ***" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

/* verification/nn_layer_core_tb.sv */
`timescale 1ns/1ps

module nn_layer_core_tb
  import nn_layer_pkg::*, nn_bus_pkg::*;
();

  localparam logic [31:0] SEED = 32'had0d_95e2;
  localparam int NUM_VECTORS   = 20;
  localparam int LOAD_TIMEOUT  = 2000;
  localparam int BEAT_TIMEOUT  = 200;
  localparam int DRAIN_TIMEOUT = 500;

  logic              clk = 1'b0;
  logic              rst;
  logic              load;
  layer_cfg_t        cfg;
  logic              cfg_ready;
  logic              load_done;
  in_beat_t          rx_beat;
  logic              rx_valid;
  logic              rx_ready;
  logic [DATA_W-1:0] tx_data;
  logic              tx_valid;
  logic              tx_last;
  logic              tx_ready = 1'b0;
  rd_addr_t          rd_addr;
  logic              ar_ready;
  rd_data_t          rd_data;
  logic              rd_ready;

  // current layer settings seen by the model
  logic [ADDR_W-1:0] cur_base;
  int                cur_n;
  logic              cur_last;
  logic [DATA_W-1:0] vec_buf [MAX_INPUTS];

  logic [DATA_W-1:0] exp_q [$];
  logic [ADDR_W-1:0] addr_log [$];
  logic [DATA_W-1:0] exp_word;
  logic              heavy_bp = 1'b0;
  int                word_idx = 0;
  int                pkt_count = 0;
  int                done_count = 0;
  int                reads_at_done = 0;
  int                sat_hi_seen = 0;
  int                sat_lo_seen = 0;
  int                err_count = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  always #4 clk = ~clk;

  nn_layer_core u_dut (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .cfg       (cfg),
    .cfg_ready (cfg_ready),
    .load_done (load_done),
    .rx_beat   (rx_beat),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_last   (tx_last),
    .tx_ready  (tx_ready),
    .rd_addr   (rd_addr),
    .ar_ready  (ar_ready),
    .rd_data   (rd_data),
    .rd_ready  (rd_ready)
  );

  weight_ram_model u_ram (
    .clk      (clk),
    .rst      (rst),
    .rd_addr  (rd_addr),
    .ar_ready (ar_ready),
    .rd_data  (rd_data),
    .rd_ready (rd_ready)
  );

  // --------------------------------------------------
  // reporting
  // --------------------------------------------------
  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, err_count - errs_before);
    end
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [DATA_W-1:0] weight_at(input int n, input int i);
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] prod;
    addr = cur_base + ADDR_W'(4 * (n * cur_n + i));
    prod = (addr >> 2) * ADDR_W'(37);
    return prod[DATA_W-1:0];
  endfunction

  function automatic logic [DATA_W-1:0] expected_result(input int n);
    longint acc;
    longint scaled;
    acc = 0;
    for (int i = 0; i < cur_n; i++) begin
      acc += longint'($signed(vec_buf[i])) * longint'($signed(weight_at(n, i)));
    end
    scaled = acc >>> FRAC_BITS;
    if (scaled > 32767) begin
      scaled = 32767;
    end else if (scaled < -32768) begin
      scaled = -32768;
    end
    // hidden layers clamp negatives
    if (!cur_last && scaled < 0) begin
      scaled = 0;
    end
    return DATA_W'(scaled);
  endfunction

  // small, medium, full range, all max, all min
  function automatic logic [DATA_W-1:0] pick_data(input int mode);
    case (mode)
      0: return DATA_W'(int'($urandom_range(32, 0)) - 16);
      1: return DATA_W'(int'($urandom_range(1024, 0)) - 512);
      3: return 16'h7fff;
      4: return 16'h8000;
      default: return DATA_W'($urandom);
    endcase
  endfunction

  // --------------------------------------------------
  // monitors
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!rst && rd_addr.valid && ar_ready) begin
      addr_log.push_back(rd_addr.addr);
    end
    if (!rst && load_done) begin
      done_count++;
      reads_at_done = addr_log.size();
    end
  end

  always @(posedge clk) begin
    if (!rst && tx_valid && tx_ready) begin
      if (exp_q.size() == 0) begin
        report_error($sformatf("unexpected output word %h", tx_data));
      end else begin
        exp_word = exp_q.pop_front();
        if (tx_data !== exp_word) begin
          report_error($sformatf("neuron %0d result %h, expected %h",
                                 word_idx, tx_data, exp_word));
        end
      end
      if (tx_last !== (word_idx == NUM_NEURONS - 1)) begin
        report_error($sformatf("tx_last %b on word %0d", tx_last, word_idx));
      end
      if (tx_data == 16'h7fff) begin
        sat_hi_seen++;
      end
      if (tx_data == 16'h8000) begin
        sat_lo_seen++;
      end
      if (word_idx == NUM_NEURONS - 1) begin
        word_idx = 0;
        pkt_count++;
      end else begin
        word_idx++;
      end
    end
  end

  // output back-pressure gets heavier in the last test
  always @(negedge clk) begin
    if (heavy_bp) begin
      tx_ready = ($urandom_range(1, 0) == 1);
    end else begin
      tx_ready = ($urandom_range(3, 0) != 0);
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic do_load(input logic [ADDR_W-1:0] base, input int n_in, input logic last);
    int cycles;
    int k;
    logic [ADDR_W-1:0] exp_addr;
    addr_log.delete();
    done_count = 0;
    if (!cfg_ready) begin
      report_error("cfg_ready low before load");
    end
    cfg.base_addr  = base;
    cfg.num_inputs = INPUT_CNT_W'(n_in);
    cfg.last_layer = last;
    load = 1'b1;
    @(negedge clk);
    load = 1'b0;
    cur_base = base;
    cur_n    = n_in;
    cur_last = last;
    cycles = 0;
    while (done_count == 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > LOAD_TIMEOUT) begin
        abort_run("load_done never pulsed after load");
      end
    end
    // a few idle cycles to catch a second pulse or stray reads
    repeat (8) @(negedge clk);
    if (done_count != 1) begin
      report_error($sformatf("load_done pulsed %0d times", done_count));
    end
    if (reads_at_done != NUM_NEURONS * n_in) begin
      report_error($sformatf("load_done after %0d reads", reads_at_done));
    end
    if (addr_log.size() != NUM_NEURONS * n_in) begin
      report_error($sformatf("%0d reads, expected %0d", addr_log.size(), NUM_NEURONS * n_in));
    end else begin
      for (int n = 0; n < NUM_NEURONS; n++) begin
        for (int i = 0; i < n_in; i++) begin
          k = n * n_in + i;
          exp_addr = base + ADDR_W'(4 * k);
          if (addr_log[k] !== exp_addr) begin
            report_error($sformatf("read %0d at %h, expected %h", k, addr_log[k], exp_addr));
          end
        end
      end
    end
  endtask

  task automatic send_vector(input int mode, input logic gaps);
    int cycles;
    for (int i = 0; i < cur_n; i++) begin
      vec_buf[i] = pick_data(mode);
    end
    for (int n = 0; n < NUM_NEURONS; n++) begin
      exp_q.push_back(expected_result(n));
    end
    for (int i = 0; i < cur_n; i++) begin
      if (gaps) begin
        repeat ($urandom_range(2, 0)) @(negedge clk);
      end
      rx_beat.data = vec_buf[i];
      rx_beat.last = (i == cur_n - 1);
      rx_valid     = 1'b1;
      cycles = 0;
      // rx_ready is stable from here to the next rising edge
      while (!rx_ready) begin
        @(negedge clk);
        cycles++;
        if (cycles > BEAT_TIMEOUT) begin
          abort_run("input beat never accepted, rx_ready stayed low");
        end
      end
      @(negedge clk);
      rx_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        abort_run("expected output words never arrived");
      end
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int errs_before;
    int pkts_before;
    void'($urandom(SEED));
    rst      = 1'b1;
    load     = 1'b0;
    cfg      = '0;
    rx_beat  = '0;
    rx_valid = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    errs_before = err_count;
    @(negedge clk);
    if (tx_valid || rx_ready || load_done || rd_addr.valid || rd_ready) begin
      report_error("outputs not low after reset");
    end
    if (!cfg_ready) begin
      report_error("cfg_ready low after reset");
    end
    close_test("reset state", errs_before);

    errs_before = err_count;
    do_load(32'h0000_1000, 8, 1'b0);
    close_test("weight fetch", errs_before);

    errs_before = err_count;
    for (int v = 0; v < NUM_VECTORS; v++) begin
      send_vector(int'($urandom_range(2, 0)), 1'b1);
      wait_drain();
    end
    close_test("hidden layer", errs_before);

    // base chosen so every neuron sees positive weights
    errs_before = err_count;
    do_load(32'h0000_2000, 5, 1'b1);
    sat_hi_seen = 0;
    sat_lo_seen = 0;
    send_vector(3, 1'b0);
    wait_drain();
    send_vector(4, 1'b0);
    wait_drain();
    for (int v = 0; v < 8; v++) begin
      send_vector(int'($urandom_range(2, 0)), 1'b1);
      wait_drain();
    end
    if (sat_hi_seen == 0 || sat_lo_seen == 0) begin
      report_error("saturated extremes missing from last layer output");
    end
    close_test("last layer", errs_before);

    errs_before = err_count;
    heavy_bp    = 1'b1;
    pkts_before = pkt_count;
    for (int v = 0; v < NUM_VECTORS; v++) begin
      send_vector(int'($urandom_range(2, 0)), 1'b0);
    end
    wait_drain();
    heavy_bp = 1'b0;
    if (pkt_count - pkts_before != NUM_VECTORS) begin
      report_error($sformatf("%0d packets, expected %0d", pkt_count - pkts_before, NUM_VECTORS));
    end
    close_test("back-pressure", errs_before);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verification/weight_ram_model.sv */
`timescale 1ns/1ps

module weight_ram_model
  import nn_layer_pkg::*, nn_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  rd_addr_t rd_addr,
  output logic     ar_ready,
  output rd_data_t rd_data,
  input  logic     rd_ready
);

  logic              ar_q = 1'b0;
  rd_data_t          rsp_q = '0;
  logic              ar_hit = 1'b0;
  logic              rsp_hit = 1'b0;
  logic              pending = 1'b0;
  logic [ADDR_W-1:0] addr_q = '0;
  logic [ADDR_W-1:0] word;
  int                delay = 0;

  assign ar_ready = ar_q;
  assign rd_data  = rsp_q;

  // handshakes seen at the rising edge
  always @(posedge clk) begin
    ar_hit  = !rst && rd_addr.valid && ar_q;
    rsp_hit = !rst && rsp_q.valid && rd_ready;
    if (ar_hit) begin
      addr_q = rd_addr.addr;
    end
  end

  // responder outputs move on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      ar_q    = 1'b0;
      rsp_q   = '0;
      pending = 1'b0;
    end else begin
      if (rsp_hit) begin
        rsp_q.valid = 1'b0;
      end
      if (ar_hit) begin
        ar_q    = 1'b0;
        pending = 1'b1;
        delay   = $urandom_range(3, 0);
      end else if (pending) begin
        if (delay == 0) begin
          // weight is word address times 37, upper half is filler
          word        = (addr_q >> 2) * ADDR_W'(37);
          rsp_q.data  = {addr_q[15:0], word[DATA_W-1:0]};
          rsp_q.valid = 1'b1;
          pending     = 1'b0;
        end else begin
          delay--;
        end
      end else if (!rsp_q.valid) begin
        ar_q = ($urandom_range(1, 0) == 1);
      end
    end
  end

endmodule

/* src/nn_layer_core.sv */
`timescale 1ns/1ps

module nn_layer_core
  import nn_layer_pkg::*, nn_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  // control
  input  logic              load,
  input  layer_cfg_t        cfg,
  output logic              cfg_ready,
  output logic              load_done,

  // input stream
  input  in_beat_t          rx_beat,
  input  logic              rx_valid,
  output logic              rx_ready,

  // output stream
  output logic [DATA_W-1:0] tx_data,
  output logic              tx_valid,
  output logic              tx_last,
  input  logic              tx_ready,

  // weight RAM read port
  output rd_addr_t          rd_addr,
  input  logic              ar_ready,
  input  rd_data_t          rd_data,
  output logic              rd_ready
);

  core_state_t state;
  layer_cfg_t  cfg_q;

  logic                               load_fire;
  logic                               start_load;
  logic                               rx_fire;
  logic                               take;
  logic                               all_valid;
  weight_wr_t                         weight_wr;
  logic [NUM_NEURONS-1:0]             neuron_ready;
  logic [NUM_NEURONS-1:0]             neuron_valid;
  logic [NUM_NEURONS-1:0][DATA_W-1:0] neuron_result;

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------
  assign cfg_ready = (state != CORE_LOADING);
  assign load_fire = load && cfg_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= CORE_IDLE;
      start_load <= 1'b0;
      cfg_q      <= '0;
    end else begin
      // loader starts once cfg_q holds the new settings
      start_load <= load_fire;
      if (load_fire) begin
        cfg_q <= cfg;
      end
      case (state)
        CORE_IDLE: begin
          if (load_fire) begin
            state <= CORE_LOADING;
          end
        end
        CORE_LOADING: begin
          if (load_done) begin
            state <= CORE_ACTIVE;
          end
        end
        CORE_ACTIVE: begin
          if (load_fire) begin
            state <= CORE_LOADING;
          end
        end
        default: state <= CORE_IDLE;
      endcase
    end
  end

  // all neurons take the beat together
  assign rx_ready  = (state == CORE_ACTIVE) && (&neuron_ready);
  assign rx_fire   = rx_valid && rx_ready;
  assign all_valid = &neuron_valid;

  // --------------------------------------------------
  // weight fetch
  // --------------------------------------------------
  weight_loader u_loader (
    .clk       (clk),
    .rst       (rst),
    .start     (start_load),
    .cfg       (cfg_q),
    .rd_addr   (rd_addr),
    .ar_ready  (ar_ready),
    .rd_data   (rd_data),
    .rd_ready  (rd_ready),
    .weight_wr (weight_wr),
    .done      (load_done)
  );

  // --------------------------------------------------
  // neurons
  // --------------------------------------------------
  for (genvar n = 0; n < NUM_NEURONS; n++) begin : g_neuron
    neuron #(
      .NEURON_ID (n)
    ) u_neuron (
      .clk          (clk),
      .rst          (rst),
      .weight_wr    (weight_wr),
      .num_inputs   (cfg_q.num_inputs),
      .last_layer   (cfg_q.last_layer),
      .rx_beat      (rx_beat),
      .rx_fire      (rx_fire),
      .ready        (neuron_ready[n]),
      .result       (neuron_result[n]),
      .result_valid (neuron_valid[n]),
      .take         (take)
    );
  end

  // --------------------------------------------------
  // transmit path
  // --------------------------------------------------
  output_serializer u_serializer (
    .clk       (clk),
    .rst       (rst),
    .results   (neuron_result),
    .all_valid (all_valid),
    .take      (take),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_last   (tx_last),
    .tx_ready  (tx_ready)
  );

  // no load command while weights are being fetched
  a_load_when_ready : assert property (
    @(posedge clk) disable iff (rst) load |-> cfg_ready
  );

endmodule

/* src/output_serializer.sv */
`timescale 1ns/1ps

module output_serializer
  import nn_layer_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  input  logic [NUM_NEURONS-1:0][DATA_W-1:0] results,
  input  logic                              all_valid,
  output logic                              take,
  output logic [DATA_W-1:0]                 tx_data,
  output logic                              tx_valid,
  output logic                              tx_last,
  input  logic                              tx_ready
);

  logic [NUM_NEURONS-1:0][DATA_W-1:0] shreg;
  logic [NEURON_SEL_W-1:0]            word_cnt;
  logic                               tx_fire;

  assign tx_fire = tx_valid && tx_ready;
  assign tx_last = tx_valid && (word_cnt == NEURON_SEL_W'(NUM_NEURONS - 1));

  // capture when idle, or right as the final word of a packet leaves
  assign take = all_valid && (!tx_valid || (tx_last && tx_ready));

  // neuron 0 sits in the low slot and goes first
  assign tx_data = shreg[0];

  // --------------------------------------------------
  // packet control
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_valid <= 1'b0;
      word_cnt <= '0;
    end else if (take) begin
      tx_valid <= 1'b1;
      word_cnt <= '0;
    end else if (tx_fire) begin
      word_cnt <= word_cnt + NEURON_SEL_W'(1);
      if (tx_last) begin
        tx_valid <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // shift register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (take) begin
      shreg <= results;
    end else if (tx_fire) begin
      shreg <= shreg >> DATA_W;
    end
  end

  // stalled word stays put until accepted
  a_tx_stable : assert property (
    @(posedge clk) disable iff (rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data)
  );

endmodule

/* src/neuron.sv */
`timescale 1ns/1ps

module neuron
  import nn_layer_pkg::*, nn_bus_pkg::*;
#(
  parameter int NEURON_ID = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  weight_wr_t             weight_wr,
  input  logic [INPUT_CNT_W-1:0] num_inputs,
  input  logic                   last_layer,
  input  in_beat_t               rx_beat,
  input  logic                   rx_fire,
  output logic                   ready,
  output logic [DATA_W-1:0]      result,
  output logic                   result_valid,
  input  logic                   take
);

  neuron_state_t state;

  logic signed [DATA_W-1:0]   weights [MAX_INPUTS];
  logic [INPUT_CNT_W-1:0]     in_idx;
  logic signed [ACC_W-1:0]    acc;
  logic signed [DATA_W-1:0]   sample;
  logic signed [DATA_W-1:0]   weight_sel;
  logic signed [2*DATA_W-1:0] product;
  logic signed [ACC_W-1:0]    scaled;
  logic signed [DATA_W-1:0]   sat_val;
  logic signed [DATA_W-1:0]   sat_q;
  logic                       release_res;

  // --------------------------------------------------
  // weight store
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (weight_wr.valid && weight_wr.sel == NEURON_SEL_W'(NEURON_ID)) begin
      weights[weight_wr.idx[WEIGHT_IDX_W-1:0]] <= weight_wr.weight;
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  assign sample     = rx_beat.data;
  assign weight_sel = weights[in_idx[WEIGHT_IDX_W-1:0]];
  assign product    = sample * weight_sel;

  // drop fraction bits, then clamp to the signed data range
  assign scaled = acc >>> FRAC_BITS;

  always_comb begin
    if (&scaled[ACC_W-1:DATA_W-1] || ~|scaled[ACC_W-1:DATA_W-1]) begin
      sat_val = scaled[DATA_W-1:0];
    end else if (scaled[ACC_W-1]) begin
      sat_val = {1'b1, {(DATA_W-1){1'b0}}};
    end else begin
      sat_val = {1'b0, {(DATA_W-1){1'b1}}};
    end
  end

  assign ready = (state == N_ACCUM);

  // result slot is free or being emptied this cycle
  assign release_res = (state == N_HOLD) && (!result_valid || take);

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= N_ACCUM;
      in_idx       <= '0;
      acc          <= '0;
      result_valid <= 1'b0;
    end else begin
      if (take) begin
        result_valid <= 1'b0;
      end
      case (state)
        N_ACCUM: begin
          if (rx_fire) begin
            acc    <= acc + ACC_W'(product);
            in_idx <= in_idx + INPUT_CNT_W'(1);
            if (rx_beat.last) begin
              state <= N_FINISH;
            end
          end
        end
        N_FINISH: begin
          // sat_q picks up the scaled sum here
          acc    <= '0;
          in_idx <= '0;
          state  <= N_HOLD;
        end
        N_HOLD: begin
          if (release_res) begin
            result_valid <= 1'b1;
            state        <= N_ACCUM;
          end
        end
        default: state <= N_ACCUM;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == N_FINISH) begin
      sat_q <= sat_val;
    end
    // relu on hidden layers only
    if (release_res) begin
      result <= (!last_layer && sat_q[DATA_W-1]) ? '0 : sat_q;
    end
  end

  // vector length must match the configured input count
  a_last_position : assert property (
    @(posedge clk) disable iff (rst)
    rx_fire |-> (rx_beat.last == (in_idx == num_inputs - INPUT_CNT_W'(1)))
  );

endmodule

/* src/weight_loader.sv */
`timescale 1ns/1ps

module weight_loader
  import nn_layer_pkg::*, nn_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  layer_cfg_t cfg,
  output rd_addr_t   rd_addr,
  input  logic       ar_ready,
  input  rd_data_t   rd_data,
  output logic       rd_ready,
  output weight_wr_t weight_wr,
  output logic       done
);

  logic                    req_valid;
  logic                    rsp_wait;
  logic [NEURON_SEL_W-1:0] neuron_idx;
  logic [INPUT_CNT_W-1:0]  input_idx;
  logic [ADDR_W-1:0]       word_offset;
  logic                    ar_fire;
  logic                    rsp_fire;
  logic                    last_input;
  logic                    last_neuron;

  assign ar_fire     = rd_addr.valid && ar_ready;
  assign rsp_fire    = rd_data.valid && rd_ready;
  assign last_input  = (input_idx == cfg.num_inputs - INPUT_CNT_W'(1));
  assign last_neuron = (neuron_idx == NEURON_SEL_W'(NUM_NEURONS - 1));

  // --------------------------------------------------
  // address of weight i of neuron n
  // --------------------------------------------------
  // base + 4 * (n * num_inputs + i)
  assign word_offset = ADDR_W'(neuron_idx) * ADDR_W'(cfg.num_inputs) + ADDR_W'(input_idx);

  assign rd_addr.valid = req_valid;
  assign rd_addr.addr  = cfg.base_addr + (word_offset << 2);
  assign rd_ready      = rsp_wait;

  // --------------------------------------------------
  // request / response sequencing
  // --------------------------------------------------
  // one read in flight, next request goes out after the response
  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid  <= 1'b0;
      rsp_wait   <= 1'b0;
      done       <= 1'b0;
      neuron_idx <= '0;
      input_idx  <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        req_valid  <= 1'b1;
        neuron_idx <= '0;
        input_idx  <= '0;
      end
      if (ar_fire) begin
        req_valid <= 1'b0;
        rsp_wait  <= 1'b1;
      end
      if (rsp_fire) begin
        rsp_wait <= 1'b0;
        if (last_input) begin
          input_idx <= '0;
          if (last_neuron) begin
            done <= 1'b1;
          end else begin
            neuron_idx <= neuron_idx + NEURON_SEL_W'(1);
            req_valid  <= 1'b1;
          end
        end else begin
          input_idx <= input_idx + INPUT_CNT_W'(1);
          req_valid <= 1'b1;
        end
      end
    end
  end

  // returned word becomes a weight write for the current neuron
  always_ff @(posedge clk) begin
    if (rst) begin
      weight_wr.valid <= 1'b0;
    end else begin
      weight_wr.valid <= rsp_fire;
    end
    if (rsp_fire) begin
      weight_wr.sel    <= neuron_idx;
      weight_wr.idx    <= input_idx;
      weight_wr.weight <= rd_data.data[DATA_W-1:0];
    end
  end

  // request and response phases never overlap
  a_single_outstanding : assert property (
    @(posedge clk) disable iff (rst) rd_ready |-> !rd_addr.valid
  );

endmodule

/* src/nn_bus_pkg.sv */
package nn_bus_pkg;
  import nn_layer_pkg::*;

  // read data width of the weight RAM port
  localparam int BUS_W = 32;

  // input stream beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } in_beat_t;

  // read request towards the weight RAM
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } rd_addr_t;

  // read response, weight sits in the low half
  typedef struct packed {
    logic             valid;
    logic [BUS_W-1:0] data;
  } rd_data_t;

  // weight write, broadcast from loader to all neurons
  typedef struct packed {
    logic                    valid;
    logic [NEURON_SEL_W-1:0] sel;
    logic [INPUT_CNT_W-1:0]  idx;
    logic [DATA_W-1:0]       weight;
  } weight_wr_t;

endpackage

/* src/nn_layer_pkg.sv */
package nn_layer_pkg;

  // --------------------------------------------------
  // layer geometry and arithmetic
  // --------------------------------------------------
  localparam int NUM_NEURONS  = 4;
  localparam int MAX_INPUTS   = 16;
  // count of inputs, must hold MAX_INPUTS itself
  localparam int INPUT_CNT_W  = 5;
  // index into a neuron's weight store
  localparam int WEIGHT_IDX_W = $clog2(MAX_INPUTS);
  // neuron select and output word counter
  localparam int NEURON_SEL_W = $clog2(NUM_NEURONS);

  localparam int DATA_W    = 16;
  localparam int ACC_W     = 40;
  localparam int FRAC_BITS = 8;
  localparam int ADDR_W    = 32;

  // --------------------------------------------------
  // layer settings, captured on a load command
  // --------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0]      base_addr;
    logic [INPUT_CNT_W-1:0] num_inputs;
    // last layer skips relu
    logic                   last_layer;
  } layer_cfg_t;

  // --------------------------------------------------
  // state encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_LOADING,
    CORE_ACTIVE
  } core_state_t;

  typedef enum logic [1:0] {
    N_ACCUM,
    N_FINISH,
    N_HOLD
  } neuron_state_t;

endpackage
